//--- files.f
source/dma_resp_pkg.sv
source/dma_flit_framer.sv
source/dma_packet_buffer.sv
source/dma_resp_writer.sv
source/dma_resp_path.sv
dv/dma_resp_path_sva.sv
dv/dma_resp_path_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the DMA response path testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -f sim.log \
  && verilator --binary --timing --assert --timescale 1ns/1ns \
       --top-module dma_resp_path_tb -Mdir obj_dir -o dma_resp_path_sim -f files.f \
  && ./obj_dir/dma_resp_path_sim +verilator+error+limit+1000 > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation run failed"; exit 1; }

cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "simulation failed"; exit 1; } \
  || echo "simulation passed"

//--- dv/dma_resp_path_tb.sv
/*
 * Testbench for the DMA response path
 * Clock, reset, NoC packet driver and bus memory model with wait states
 * Directed tests for completions, bursts, back-pressure and dropped packets
 */

`timescale 1ns/1ns

module dma_resp_path_tb;

  localparam int buffer_depth  = 16;
  localparam int clk_period_ns = 4;
  // Watchdog budget from the worst case per flit
  localparam int max_packets   = 20;
  localparam int max_pkt_flits = 16;
  localparam int wait_factor   = 8;
  localparam int timeout_ns    = (max_packets * max_pkt_flits * wait_factor + 10) * clk_period_ns;

  logic        clk;
  logic        rst;
  logic [33:0] noc_flit;
  logic        noc_valid;
  logic        noc_ready;
  logic        bus_sel;
  logic        bus_write;
  logic        bus_lock;
  logic [1:0]  bus_trans;
  logic [31:0] bus_addr;
  logic [31:0] bus_wdata;
  logic        bus_ready = 1'b1;
  logic        done_en;
  logic [3:0]  done_id;

  logic        wait_mode = 1'b0;
  integer      seed      = 32'h33c1_7286;
  integer      stim_seed = 32'h33c1_7286;

  // Expected and observed traffic
  logic [31:0] exp_addr[$];
  logic [31:0] exp_data[$];
  logic [1:0]  exp_trans[$];
  logic [3:0]  exp_done[$];
  logic [31:0] got_addr[$];
  logic [31:0] got_data[$];
  logic [1:0]  got_trans[$];
  logic [3:0]  got_done[$];
  logic [33:0] tx_q[$];

  int checked_writes  = 0;
  int checked_dones   = 0;
  int value_errors    = 0;
  int count_errors    = 0;
  int protocol_errors = 0;

  dma_resp_path #(.buffer_depth(buffer_depth)) u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #(clk_period_ns / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Bus memory model
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    logic [31:0] r;
    if (!rst) begin
      if (bus_sel && bus_ready) begin
        got_addr.push_back(bus_addr);
        got_data.push_back(bus_wdata);
        got_trans.push_back(bus_trans);
        assert (bus_write && bus_lock) else begin
          protocol_errors++;
          $display("write beat at %0t without bus_write and bus_lock held", $time);
        end
      end
      if (done_en) begin
        got_done.push_back(done_id);
      end
    end
    // Random wait states on about half the cycles
    if (wait_mode) begin
      r = $random(seed);
      bus_ready <= r[0];
    end else begin
      bus_ready <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Packet building and NoC driver
  ////////////////////////////////////////////////////////////

  function automatic logic [33:0] make_flit(input logic [1:0] ftype, input logic [31:0] c);
    return {ftype, c};
  endfunction

  // Type in 31:28, response-last in 27, id in 3:0
  function automatic logic [31:0] header_word(input logic [3:0] ptype, input logic last,
                                              input logic [3:0] id);
    return {ptype, last, 23'd0, id};
  endfunction

  task automatic queue_l2r(input logic [3:0] id);
    tx_q.push_back(make_flit(dma_resp_pkg::flit_single,
                             header_word(dma_resp_pkg::pkt_type_l2r_resp, 1'b1, id)));
    exp_done.push_back(id);
  endtask

  // Header, size, address, then n data words
  task automatic queue_r2l(input logic [3:0] id, input logic resp_last,
                           input logic [31:0] addr, input int n);
    logic [31:0] d;
    tx_q.push_back(make_flit(dma_resp_pkg::flit_first,
                             header_word(dma_resp_pkg::pkt_type_r2l_resp, resp_last, id)));
    tx_q.push_back(make_flit(dma_resp_pkg::flit_middle, 32'(n)));
    tx_q.push_back(make_flit(dma_resp_pkg::flit_middle, addr));
    for (int k = 0; k < n; k++) begin
      d = $random(stim_seed);
      tx_q.push_back(make_flit((k == n - 1) ? dma_resp_pkg::flit_last
                                            : dma_resp_pkg::flit_middle, d));
      exp_addr.push_back(addr + 32'(4 * k));
      exp_data.push_back(d);
      exp_trans.push_back((k == 0) ? dma_resp_pkg::trans_nonseq : dma_resp_pkg::trans_seq);
    end
    if (resp_last) begin
      exp_done.push_back(id);
    end
  endtask

  // Unknown type that should vanish entirely
  task automatic queue_unknown(input logic [3:0] ptype, input int n_body);
    if (n_body == 0) begin
      tx_q.push_back(make_flit(dma_resp_pkg::flit_single, header_word(ptype, 1'b1, 4'hc)));
    end else begin
      tx_q.push_back(make_flit(dma_resp_pkg::flit_first, header_word(ptype, 1'b1, 4'hc)));
      for (int k = 0; k < n_body; k++) begin
        tx_q.push_back(make_flit((k == n_body - 1) ? dma_resp_pkg::flit_last
                                                   : dma_resp_pkg::flit_middle, 32'(k)));
      end
    end
  endtask

  // Sends every queued flit with optional idle gaps
  task automatic send_queued(input int max_gap);
    int gap;
    foreach (tx_q[i]) begin
      gap = (max_gap > 0) ? int'({$random(stim_seed)} % (max_gap + 1)) : 0;
      repeat (gap) begin
        noc_valid <= 1'b0;
        @(posedge clk);
      end
      noc_flit  <= tx_q[i];
      noc_valid <= 1'b1;
      @(posedge clk);
      while (!noc_ready) @(posedge clk);
    end
    noc_valid <= 1'b0;
    tx_q.delete();
  endtask

  ////////////////////////////////////////////////////////////
  // Result checking
  ////////////////////////////////////////////////////////////

  // A response-last done coincides with its last beat
  task automatic wait_results();
    while (got_addr.size() < exp_addr.size() || got_done.size() < exp_done.size())
      @(negedge clk);
    @(posedge clk);
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      value_errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_results(input string test_name);
    assert (got_addr.size() == exp_addr.size()) else begin
      count_errors++;
      $display("wrong number of bus writes in %s: %0d seen, %0d expected",
               test_name, got_addr.size(), exp_addr.size());
    end
    assert (got_done.size() == exp_done.size()) else begin
      count_errors++;
      $display("wrong number of completions in %s: %0d seen, %0d expected",
               test_name, got_done.size(), exp_done.size());
    end
    for (int i = checked_writes; i < exp_addr.size() && i < got_addr.size(); i++) begin
      check_value("bus_addr", got_addr[i], exp_addr[i]);
      check_value("bus_wdata", got_data[i], exp_data[i]);
      check_value("bus_trans", 32'(got_trans[i]), 32'(exp_trans[i]));
    end
    for (int i = checked_dones; i < exp_done.size() && i < got_done.size(); i++) begin
      check_value("done_id", 32'(got_done[i]), 32'(exp_done[i]));
    end
    checked_writes = exp_addr.size();
    checked_dones  = exp_done.size();
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic test_l2r_completion();
    queue_l2r(4'h5);
    send_queued(0);
    wait_results();
    check_results("l2r completion");
  endtask

  // Multi-word burst and a single-word burst
  task automatic test_r2l_burst();
    queue_r2l(4'h9, 1'b1, 32'h0000_1000, 5);
    queue_r2l(4'ha, 1'b1, 32'h0000_1800, 1);
    send_queued(0);
    wait_results();
    check_results("r2l burst");
  endtask

  task automatic test_r2l_no_completion();
    queue_r2l(4'h3, 1'b0, 32'h0000_2040, 3);
    send_queued(0);
    wait_results();
    check_results("r2l without response-last");
  endtask

  // Back-to-back flits far beyond the buffer depth so bus stalls fill it
  task automatic test_stall_stream();
    wait_mode <= 1'b1;
    for (int k = 0; k < 10; k++) begin
      if (k % 3 == 2) begin
        queue_l2r(4'(k));
      end else begin
        queue_r2l(4'(k), (k % 4) != 1, 32'h0001_0000 + 32'(k * 256),
                  1 + int'({$random(stim_seed)} % 10));
      end
    end
    send_queued(0);
    wait_results();
    wait_mode <= 1'b0;
    check_results("stalled packet stream");
  endtask

  task automatic test_unknown_drop();
    queue_r2l(4'h1, 1'b1, 32'h0000_3000, 2);
    queue_unknown(4'h7, 4);
    queue_unknown(4'hf, 0);
    queue_l2r(4'h2);
    send_queued(1);
    wait_results();
    check_results("unknown type dropped");
  endtask

  ////////////////////////////////////////////////////////////
  // Sequence, summary and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    int sva_fails;
    int total;
    rst       = 1'b1;
    noc_flit  = '0;
    noc_valid = 1'b0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    test_l2r_completion();
    test_r2l_burst();
    test_r2l_no_completion();
    test_stall_stream();
    test_unknown_drop();
    sva_fails = u_dut.u_sva.stall_fails + u_dut.u_sva.done_fails + u_dut.u_sva.reset_fails;
    total     = value_errors + count_errors + protocol_errors + sva_fails;
    $write("summary: %0d value mismatches, %0d count errors, ", value_errors, count_errors);
    $display("%0d protocol errors, %0d assertion failures", protocol_errors, sva_fails);
    if (total == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin
    #(timeout_ns);
    $display("watchdog expired after %0d ns, the DUT stopped making progress", timeout_ns);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

//--- dv/dma_resp_path_sva.sv
/*
 * Protocol checks for the DMA response path, bound to the top level
 * Bus address and data held in wait states, done pulse width, bus idle after reset
 */

`timescale 1ns/1ns

module dma_resp_path_sva (
  input logic                                    clk,
  input logic                                    rst,
  input logic                                    bus_sel,
  input logic                                    bus_ready,
  input logic [dma_resp_pkg::bus_addr_width-1:0] bus_addr,
  input logic [dma_resp_pkg::bus_addr_width-1:0] bus_wdata,
  input logic                                    done_en,
  input logic [dma_resp_pkg::table_id_width-1:0] done_id
);

  // Per-property failure tallies
  int stall_fails = 0;
  int done_fails  = 0;
  int reset_fails = 0;

  // A stalled beat keeps select, address and data
  a_stall_hold: assert property (@(posedge clk) disable iff (rst)
    bus_sel && !bus_ready |=> bus_sel && $stable(bus_addr) && $stable(bus_wdata))
  else begin
    stall_fails++;
    $error("bus_addr or bus_wdata changed during a wait state");
  end

  // Back-to-back completions always carry a new id
  a_done_pulse: assert property (@(posedge clk) disable iff (rst)
    done_en |=> !done_en || (done_id != $past(done_id)))
  else begin
    done_fails++;
    $error("done_en held for two cycles with the same id");
  end

  // Nothing selected right after reset
  a_reset_idle: assert property (@(posedge clk) $past(rst) |-> !bus_sel && !done_en)
  else begin
    reset_fails++;
    $error("bus_sel or done_en active right after reset");
  end

endmodule

bind dma_resp_path dma_resp_path_sva u_sva (
  .clk       (clk),
  .rst       (rst),
  .bus_sel   (bus_sel),
  .bus_ready (bus_ready),
  .bus_addr  (bus_addr),
  .bus_wdata (bus_wdata),
  .done_en   (done_en),
  .done_id   (done_id)
);

//--- source/dma_resp_path.sv
/*
 * Top level of the DMA response path
 * NoC framer, packet buffer and AHB-Lite writer in a chain
 */

`timescale 1ns/1ns

module dma_resp_path #(
  parameter int buffer_depth = 16
) (
  input  logic                                    clk,
  input  logic                                    rst,
  // NoC side
  input  logic [dma_resp_pkg::flit_width-1:0]     noc_flit,
  input  logic                                    noc_valid,
  output logic                                    noc_ready,
  // Bus side
  output logic                                    bus_sel,
  output logic                                    bus_write,
  output logic                                    bus_lock,
  output logic [1:0]                              bus_trans,
  output logic [dma_resp_pkg::bus_addr_width-1:0] bus_addr,
  output logic [dma_resp_pkg::bus_addr_width-1:0] bus_wdata,
  input  logic                                    bus_ready,
  // Completion
  output logic                                    done_en,
  output logic [dma_resp_pkg::table_id_width-1:0] done_id
);

  dma_resp_pkg::dma_flit_t frm_flit;
  logic                    frm_valid;
  logic                    frm_ready;
  dma_resp_pkg::dma_flit_t buf_flit;
  logic                    buf_valid;
  logic                    buf_ready;

  // Header decode and drop of unknown packets
  dma_flit_framer u_framer (
    .clk       (clk),
    .rst       (rst),
    .noc_flit  (noc_flit),
    .noc_valid (noc_valid),
    .noc_ready (noc_ready),
    .frm_flit  (frm_flit),
    .frm_valid (frm_valid),
    .frm_ready (frm_ready)
  );

  // Absorbs one full packet
  dma_packet_buffer #(
    .buffer_depth (buffer_depth)
  ) u_buffer (
    .clk       (clk),
    .rst       (rst),
    .in_flit   (frm_flit),
    .in_valid  (frm_valid),
    .in_ready  (frm_ready),
    .out_flit  (buf_flit),
    .out_valid (buf_valid),
    .out_ready (buf_ready)
  );

  dma_resp_writer u_writer (
    .clk       (clk),
    .rst       (rst),
    .buf_flit  (buf_flit),
    .buf_valid (buf_valid),
    .buf_ready (buf_ready),
    .bus_sel   (bus_sel),
    .bus_write (bus_write),
    .bus_lock  (bus_lock),
    .bus_trans (bus_trans),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .bus_ready (bus_ready),
    .done_en   (done_en),
    .done_id   (done_id)
  );

endmodule

//--- source/dma_resp_writer.sv
/*
 * Bus writer of the DMA response path
 * FSM turning remote-to-local responses into AHB-Lite word writes
 * Pulses the completion strobe for finished table entries
 */

`timescale 1ns/1ns

module dma_resp_writer (
  input  logic                                    clk,
  input  logic                                    rst,
  input  dma_resp_pkg::dma_flit_t                 buf_flit,
  input  logic                                    buf_valid,
  output logic                                    buf_ready,
  output logic                                    bus_sel,
  output logic                                    bus_write,
  output logic                                    bus_lock,
  output logic [1:0]                              bus_trans,
  output logic [dma_resp_pkg::bus_addr_width-1:0] bus_addr,
  output logic [dma_resp_pkg::bus_addr_width-1:0] bus_wdata,
  input  logic                                    bus_ready,
  output logic                                    done_en,
  output logic [dma_resp_pkg::table_id_width-1:0] done_id
);

  typedef enum logic [1:0] {
    st_idle     = 2'd0,
    st_get_size = 2'd1,
    st_get_addr = 2'd2,
    st_data     = 2'd3
  } state_t;

  state_t                                  state;
  state_t                                  state_next;
  logic [dma_resp_pkg::bus_addr_width-1:0] addr_q;
  logic [dma_resp_pkg::bus_addr_width-1:0] addr_next;
  logic [dma_resp_pkg::table_id_width-1:0] resp_id;
  logic [dma_resp_pkg::table_id_width-1:0] resp_id_next;
  logic                                    resp_last;
  logic                                    resp_last_next;
  logic                                    first_beat;
  logic                                    first_beat_next;
  logic                                    beat;

  assign bus_addr  = addr_q;
  // Write data comes straight from the buffer head
  assign bus_wdata = buf_flit.content;
  assign beat      = bus_sel && bus_ready;

  ////////////////////////////////////////////////////////////
  // Next state and bus outputs
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_next      = state;
    addr_next       = addr_q;
    resp_id_next    = resp_id;
    resp_last_next  = resp_last;
    first_beat_next = first_beat;

    buf_ready = 1'b0;
    bus_sel   = 1'b0;
    bus_write = 1'b0;
    bus_lock  = 1'b0;
    bus_trans = dma_resp_pkg::trans_idle;
    done_en   = 1'b0;
    done_id   = resp_id;

    case (state)
      st_idle: begin
        // One header per cycle
        buf_ready = 1'b1;
        if (buf_valid && buf_flit.is_first) begin
          case (buf_flit.kind)
            dma_resp_pkg::kind_l2r_resp: begin
              done_en = 1'b1;
              done_id = buf_flit.id;
            end
            dma_resp_pkg::kind_r2l_resp: begin
              resp_id_next   = buf_flit.id;
              resp_last_next = buf_flit.resp_last;
              state_next     = st_get_size;
            end
            default: state_next = st_idle;
          endcase
        end
      end
      st_get_size: begin
        // Size flit is not needed, the last tag ends the burst
        buf_ready = 1'b1;
        if (buf_valid) begin
          state_next = st_get_addr;
        end
      end
      st_get_addr: begin
        buf_ready = 1'b1;
        if (buf_valid) begin
          addr_next       = buf_flit.content;
          first_beat_next = 1'b1;
          state_next      = st_data;
        end
      end
      st_data: begin
        // Lock held across the burst, select only with data present
        bus_lock  = 1'b1;
        bus_sel   = buf_valid;
        bus_write = buf_valid;
        if (buf_valid) begin
          bus_trans = first_beat ? dma_resp_pkg::trans_nonseq : dma_resp_pkg::trans_seq;
        end
        buf_ready = bus_ready;
        if (beat) begin
          addr_next       = addr_q + dma_resp_pkg::bus_addr_width'(4);
          first_beat_next = 1'b0;
          if (buf_flit.is_last) begin
            state_next = st_idle;
            if (resp_last) begin
              done_en = 1'b1;
              done_id = resp_id;
            end
          end
        end
      end
      default: state_next = st_idle;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= st_idle;
      first_beat <= 1'b0;
    end else begin
      state      <= state_next;
      first_beat <= first_beat_next;
    end
  end

  // Burst address and latched header fields
  always_ff @(posedge clk) begin
    addr_q    <= addr_next;
    resp_id   <= resp_id_next;
    resp_last <= resp_last_next;
  end

endmodule

//--- source/dma_packet_buffer.sv
/*
 * Packet buffer between the framer and the bus writer
 * Circular FIFO of decoded flits, valid/ready on both sides
 * Read and write may happen in the same cycle
 */

`timescale 1ns/1ns

module dma_packet_buffer #(
  parameter int buffer_depth = 16
) (
  input  logic                    clk,
  input  logic                    rst,
  input  dma_resp_pkg::dma_flit_t in_flit,
  input  logic                    in_valid,
  output logic                    in_ready,
  output dma_resp_pkg::dma_flit_t out_flit,
  output logic                    out_valid,
  input  logic                    out_ready
);

  ////////////////////////////////////////////////////////////
  // Storage and pointers
  ////////////////////////////////////////////////////////////

  // Depth is a power of two so pointers wrap on their own
  localparam int ptr_width = $clog2(buffer_depth);
  localparam logic [ptr_width:0] full_count = (ptr_width + 1)'(buffer_depth);

  dma_resp_pkg::dma_flit_t mem [buffer_depth];

  logic [ptr_width-1:0] wr_ptr;
  logic [ptr_width-1:0] rd_ptr;
  logic [ptr_width:0]   count;
  logic                 do_write;
  logic                 do_read;

  // Full blocks the framer, empty hides the output
  assign in_ready  = (count != full_count);
  assign out_valid = (count != '0);
  assign out_flit  = mem[rd_ptr];

  assign do_write = in_valid && in_ready;
  assign do_read  = out_valid && out_ready;

  ////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_read) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous read and write keeps the count
      case ({do_write, do_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Flit memory
  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[wr_ptr] <= in_flit;
    end
  end

endmodule

//--- source/dma_flit_framer.sv
/*
 * NoC input stage of the DMA response path
 * One register stage with valid/ready on both sides
 * Decodes each packet header once and tags every flit with first/last
 * Packets with an unknown type are accepted and dropped
 */

`timescale 1ns/1ns

module dma_flit_framer (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [dma_resp_pkg::flit_width-1:0] noc_flit,
  input  logic                                noc_valid,
  output logic                                noc_ready,
  output dma_resp_pkg::dma_flit_t             frm_flit,
  output logic                                frm_valid,
  input  logic                                frm_ready
);

  dma_resp_pkg::flit_type_t                in_type;
  dma_resp_pkg::pkt_kind_t                 hdr_kind;
  dma_resp_pkg::dma_flit_t                 next_flit;
  logic [3:0]                              in_pkt_type;
  logic                                    in_end;
  logic                                    accept;
  logic                                    forward;
  logic                                    expect_header;
  logic                                    dropping;
  logic                                    hdr_resp_last;
  logic [dma_resp_pkg::table_id_width-1:0] hdr_id;

  // Stage can take a flit when empty or draining this cycle
  assign noc_ready = !frm_valid || frm_ready;
  assign accept    = noc_valid && noc_ready;

  assign in_type     = dma_resp_pkg::flit_type_t'(noc_flit[dma_resp_pkg::flit_type_msb:
                                                           dma_resp_pkg::flit_type_lsb]);
  assign in_end      = (in_type == dma_resp_pkg::flit_last) ||
                       (in_type == dma_resp_pkg::flit_single);
  assign in_pkt_type = noc_flit[dma_resp_pkg::pkt_type_msb:dma_resp_pkg::pkt_type_lsb];

  // Header decode, unknown codes map to none
  always_comb begin
    case (in_pkt_type)
      dma_resp_pkg::pkt_type_l2r_resp: hdr_kind = dma_resp_pkg::kind_l2r_resp;
      dma_resp_pkg::pkt_type_r2l_resp: hdr_kind = dma_resp_pkg::kind_r2l_resp;
      default:                         hdr_kind = dma_resp_pkg::kind_none;
    endcase
  end

  // Unknown header or rest of a dropped packet goes nowhere
  assign forward = expect_header ? (hdr_kind != dma_resp_pkg::kind_none) : !dropping;

  always_comb begin
    next_flit.content  = noc_flit[dma_resp_pkg::content_msb:dma_resp_pkg::content_lsb];
    next_flit.is_first = expect_header;
    next_flit.is_last  = in_end;
    if (expect_header) begin
      next_flit.kind      = hdr_kind;
      next_flit.resp_last = noc_flit[dma_resp_pkg::resp_last_bit];
      next_flit.id        = noc_flit[dma_resp_pkg::id_msb:dma_resp_pkg::id_lsb];
    end else begin
      // Body flits carry the header's id and flag
      next_flit.kind      = dma_resp_pkg::kind_none;
      next_flit.resp_last = hdr_resp_last;
      next_flit.id        = hdr_id;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      frm_valid     <= 1'b0;
      expect_header <= 1'b1;
      dropping      <= 1'b0;
    end else begin
      if (accept) begin
        expect_header <= in_end;
        if (expect_header) begin
          dropping <= (hdr_kind == dma_resp_pkg::kind_none) && !in_end;
        end else if (in_end) begin
          dropping <= 1'b0;
        end
      end
      if (accept && forward) begin
        frm_valid <= 1'b1;
      end else if (frm_ready) begin
        frm_valid <= 1'b0;
      end
    end
  end

  // Payload and header fields
  always_ff @(posedge clk) begin
    if (accept && forward) begin
      frm_flit <= next_flit;
    end
    if (accept && expect_header) begin
      hdr_id        <= noc_flit[dma_resp_pkg::id_msb:dma_resp_pkg::id_lsb];
      hdr_resp_last <= noc_flit[dma_resp_pkg::resp_last_bit];
    end
  end

endmodule

//--- source/dma_resp_pkg.sv
/*
 * Shared definitions for the DMA response path
 * NoC flit layout, header field positions and packet type codes
 * Decoded packet kinds and the decoded flit struct
 * AHB-Lite transfer codes used on the write side
 */

package dma_resp_pkg;

  ////////////////////////////////////////////////////////////
  // NoC flit layout
  ////////////////////////////////////////////////////////////

  // Two framing bits on top of a 32-bit content field
  localparam int flit_width    = 34;
  localparam int flit_type_msb = 33;
  localparam int flit_type_lsb = 32;
  localparam int content_width = 32;
  localparam int content_msb   = 31;
  localparam int content_lsb   = 0;

  // Framing code carried in the top two bits
  typedef enum logic [1:0] {
    flit_middle = 2'd0,
    flit_first  = 2'd1,
    flit_last   = 2'd2,
    flit_single = 2'd3
  } flit_type_t;

  // Header fields, all inside the content field
  localparam int pkt_type_msb  = 31;
  localparam int pkt_type_lsb  = 28;
  localparam int resp_last_bit = 27;
  localparam int id_msb        = 3;
  localparam int id_lsb        = 0;

  // Raw packet type codes
  localparam logic [3:0] pkt_type_l2r_resp = 4'h2;
  localparam logic [3:0] pkt_type_r2l_resp = 4'h3;

  // Enough for one transfer table entry number
  localparam int table_id_width = 4;

  ////////////////////////////////////////////////////////////
  // Decoded flit
  ////////////////////////////////////////////////////////////

  // Kind is only set on the header flit of a packet
  typedef enum logic [1:0] {
    kind_none     = 2'd0,
    kind_l2r_resp = 2'd1,
    kind_r2l_resp = 2'd2
  } pkt_kind_t;

  typedef struct packed {
    pkt_kind_t                 kind;
    logic                      is_first;
    logic                      is_last;
    logic                      resp_last;
    logic [table_id_width-1:0] id;
    logic [content_width-1:0]  content;
  } dma_flit_t;

  // Bus side
  localparam int         bus_addr_width = 32;
  localparam logic [1:0] trans_idle     = 2'b00;
  localparam logic [1:0] trans_nonseq   = 2'b10;
  localparam logic [1:0] trans_seq      = 2'b11;

endpackage
